// File: Bender.yml
package:
  name: arcade_video

sources:
  - common/arcade_video_pkg.sv
  - source/pixel_capture.sv
  - rotate/rotate_writer.sv
  - rotate/frame_buffer.sv
  - rotate/rotate_reader.sv
  - source/video_out_ctrl.sv
  - source/arcade_video_top.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/arcade_video_tb.sv

// File: common/arcade_video_pkg.sv
// Shared geometry, output timing and types for the arcade video output stage
// Referenced by every RTL block through scoped names

package arcade_video_pkg;

    // ============================================================
    // Source frame geometry
    // ============================================================
    localparam int src_width  = 16;
    localparam int src_height = 12;
    localparam int bank_size  = src_width * src_height;
    localparam int addr_w     = $clog2(2 * bank_size);

    // ============================================================
    // Rotated output timing, in output ticks and lines
    // ============================================================
    localparam int out_line_len     = src_height + 18;
    localparam int out_hs_start     = src_height + 8;
    localparam int out_hs_end       = src_height + 10;
    localparam int out_vblank_lines = 4;
    localparam int out_vs_start     = 1;
    localparam int out_vs_end       = 3;

    // Wide enough for output ticks per line and lines per frame
    localparam int cnt_w = $clog2(out_line_len + 1);

    typedef logic [cnt_w-1:0]  cnt_t;
    typedef logic [addr_w-1:0] addr_t;

    // RGB332 source pixel
    typedef struct packed {
        logic [2:0] r;
        logic [2:0] g;
        logic [1:0] b;
    } pix_t;

    // Captured pixel with its sync and blanking
    typedef struct packed {
        pix_t pix;
        logic hs;
        logic vs;
        logic hblank;
        logic vblank;
    } video_t;

    // Expanded output colour, 8 bits per channel
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        logic       no_rotate;
        logic       ccw;
        logic [2:0] fx;
    } mode_t;

    // Line phase of the rotated output
    typedef enum logic [1:0] {
        active,
        hblank,
        vblank
    } rd_phase_e;

endpackage

// File: rotate/frame_buffer.sv
// Two-bank pixel store, one write port and one registered read port
// Bank 0 sits in the lower half of the address range, bank 1 above it

`timescale 1ns/1ps

module frame_buffer (
    input  logic                                clk,
    input  logic                                wr_en,
    input  logic [arcade_video_pkg::addr_w-1:0] wr_addr,
    input  logic [arcade_video_pkg::addr_w-1:0] rd_addr,
    input  arcade_video_pkg::pix_t              wr_data,
    output arcade_video_pkg::pix_t              rd_data
);

    arcade_video_pkg::pix_t mem [2 * arcade_video_pkg::bank_size];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

// File: rotate/rotate_reader.sv
// Read side of the rotation buffer with its own line and frame timing
// Output timing targets a scaler input and matches no TV or VGA mode

`timescale 1ns/1ps

module rotate_reader (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                tick,
    input  logic                                bank,
    output logic [arcade_video_pkg::addr_w-1:0] rd_addr,
    output logic                                rd_tick,
    output arcade_video_pkg::rd_phase_e         phase,
    output logic                                rot_hs,
    output logic                                rot_vs
);

    arcade_video_pkg::cnt_t xo;
    arcade_video_pkg::cnt_t yo;
    logic                   last_line;
    logic                   bank_d;
    logic                   pend;

    assign last_line = (yo == arcade_video_pkg::src_width + arcade_video_pkg::out_vblank_lines - 1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            xo      <= '0;
            yo      <= arcade_video_pkg::cnt_t'(arcade_video_pkg::src_width +
                                                arcade_video_pkg::out_vblank_lines - 1);
            rd_addr <= '0;
            rd_tick <= 1'b0;
            phase   <= arcade_video_pkg::vblank;
            rot_hs  <= 1'b0;
            rot_vs  <= 1'b0;
            bank_d  <= 1'b0;
            pend    <= 1'b0;
        end else begin
            bank_d  <= bank;
            rd_tick <= tick;
            if (tick) begin
                // ============================================================
                // Timing of the pixel at this tick
                // ============================================================
                rot_hs <= (xo >= arcade_video_pkg::out_hs_start) &&
                          (xo <  arcade_video_pkg::out_hs_end);
                rot_vs <= (yo >= arcade_video_pkg::src_width + arcade_video_pkg::out_vs_start) &&
                          (yo <  arcade_video_pkg::src_width + arcade_video_pkg::out_vs_end);
                if (yo >= arcade_video_pkg::src_width) begin
                    phase <= arcade_video_pkg::vblank;
                end else if (xo >= arcade_video_pkg::src_height) begin
                    phase <= arcade_video_pkg::hblank;
                end else begin
                    phase   <= arcade_video_pkg::active;
                    rd_addr <= rd_addr + 1'b1;
                end

                // ============================================================
                // Line and frame counters
                // ============================================================
                if (xo == arcade_video_pkg::out_line_len - 1) begin
                    xo <= '0;
                    if (!last_line) begin
                        yo <= yo + 1'b1;
                    end else if (pend) begin
                        // Restart on the bank the writer just finished
                        yo      <= '0;
                        pend    <= 1'b0;
                        rd_addr <= bank ? '0 :
                                   arcade_video_pkg::addr_t'(arcade_video_pkg::bank_size);
                    end
                end else begin
                    xo <= xo + 1'b1;
                end
            end
            // A new bank must not be lost to a restart in the same cycle
            if (bank != bank_d) begin
                pend <= 1'b1;
            end
        end
    end

endmodule

// File: rotate/rotate_writer.sv
// Write side of the rotation buffer
// Walks the frame store column-wise so each source line lands as an output column

`timescale 1ns/1ps

module rotate_writer (
    input  logic                                clk,
    input  logic                                arst_n,
    input  arcade_video_pkg::video_t            cap,
    input  logic                                cap_ce,
    input  logic                                ccw_active,
    output logic                                wr_en,
    output logic [arcade_video_pkg::addr_w-1:0] wr_addr,
    output logic                                bank
);

    arcade_video_pkg::addr_t row_base;
    arcade_video_pkg::addr_t row_next;
    arcade_video_pkg::addr_t start;
    arcade_video_pkg::cnt_t  x;
    arcade_video_pkg::cnt_t  y;
    logic                    blank;
    logic                    blank_d;
    logic                    vblank_d;

    assign blank = cap.hblank | cap.vblank;
    assign wr_en = cap_ce & ~blank &
                   (x < arcade_video_pkg::src_width) & (y < arcade_video_pkg::src_height);

    assign row_next = ccw_active ? row_base + 1'b1 : row_base - 1'b1;

    // Start corner of the bank not being filled now
    always_comb begin
        if (ccw_active) begin
            start = arcade_video_pkg::addr_t'(arcade_video_pkg::bank_size) -
                    arcade_video_pkg::addr_t'(arcade_video_pkg::src_height);
        end else begin
            start = arcade_video_pkg::addr_t'(arcade_video_pkg::src_height) - 1'b1;
        end
        if (!bank) begin
            start = start + arcade_video_pkg::addr_t'(arcade_video_pkg::bank_size);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_addr  <= '0;
            row_base <= '0;
            x        <= '0;
            y        <= arcade_video_pkg::cnt_t'(arcade_video_pkg::src_height);
            blank_d  <= 1'b1;
            vblank_d <= 1'b1;
            bank     <= 1'b0;
        end else begin
            blank_d  <= blank;
            vblank_d <= cap.vblank;
            if (wr_en) begin
                wr_addr <= ccw_active ?
                           wr_addr - arcade_video_pkg::addr_t'(arcade_video_pkg::src_height) :
                           wr_addr + arcade_video_pkg::addr_t'(arcade_video_pkg::src_height);
                x       <= x + 1'b1;
            end
            // End of a visible line: move to the next column of the output
            if (blank && !blank_d) begin
                wr_addr  <= row_next;
                row_base <= row_next;
                x        <= '0;
                if (y < arcade_video_pkg::src_height) begin
                    y <= y + 1'b1;
                end
            end
            if (cap.vblank && !vblank_d) begin
                wr_addr  <= start;
                row_base <= start;
                x        <= '0;
                y        <= '0;
                bank     <= ~bank;
            end
        end
    end

endmodule

// File: source/arcade_video_top.sv
// Top level of the video output stage
// Capture feeds both the direct path and the +90/-90 degree rotation buffer

`timescale 1ns/1ps

module arcade_video_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    ce_pix,
    input  arcade_video_pkg::pix_t  pix_in,
    input  logic                    hsync,
    input  logic                    vsync,
    input  logic                    hblank,
    input  logic                    vblank,
    input  arcade_video_pkg::mode_t mode,
    output logic                    out_ce,
    output arcade_video_pkg::rgb_t  rgb,
    output logic                    hs,
    output logic                    vs,
    output logic                    de,
    output logic [1:0]              scanline
);

    arcade_video_pkg::video_t            cap;
    logic                                cap_ce;
    logic                                ccw_active;
    logic                                wr_en;
    logic [arcade_video_pkg::addr_w-1:0] wr_addr;
    logic [arcade_video_pkg::addr_w-1:0] rd_addr;
    logic                                bank;
    arcade_video_pkg::pix_t              rd_data;
    logic                                rd_tick;
    arcade_video_pkg::rd_phase_e         phase;
    logic                                rot_hs;
    logic                                rot_vs;

    pixel_capture u_capture (
        .clk    (clk),
        .arst_n (arst_n),
        .ce_pix (ce_pix),
        .pix_in (pix_in),
        .hsync  (hsync),
        .vsync  (vsync),
        .hblank (hblank),
        .vblank (vblank),
        .cap    (cap),
        .cap_ce (cap_ce)
    );

    rotate_writer u_writer (
        .clk        (clk),
        .arst_n     (arst_n),
        .cap        (cap),
        .cap_ce     (cap_ce),
        .ccw_active (ccw_active),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .bank       (bank)
    );

    frame_buffer u_buffer (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .rd_addr (rd_addr),
        .wr_data (cap.pix),
        .rd_data (rd_data)
    );

    // One output tick per captured source pixel
    rotate_reader u_reader (
        .clk     (clk),
        .arst_n  (arst_n),
        .tick    (cap_ce),
        .bank    (bank),
        .rd_addr (rd_addr),
        .rd_tick (rd_tick),
        .phase   (phase),
        .rot_hs  (rot_hs),
        .rot_vs  (rot_vs)
    );

    video_out_ctrl u_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .mode       (mode),
        .cap        (cap),
        .cap_ce     (cap_ce),
        .rd_data    (rd_data),
        .rd_tick    (rd_tick),
        .phase      (phase),
        .rot_hs     (rot_hs),
        .rot_vs     (rot_vs),
        .ccw_active (ccw_active),
        .out_ce     (out_ce),
        .rgb        (rgb),
        .hs         (hs),
        .vs         (vs),
        .de         (de),
        .scanline   (scanline)
    );

endmodule

// File: source/pixel_capture.sv
// Registers the incoming pixel stream on each rising edge of the pixel enable
// Frame markers are realigned so downstream blocks see clean line and frame starts

`timescale 1ns/1ps

module pixel_capture (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     ce_pix,
    input  arcade_video_pkg::pix_t   pix_in,
    input  logic                     hsync,
    input  logic                     vsync,
    input  logic                     hblank,
    input  logic                     vblank,
    output arcade_video_pkg::video_t cap,
    output logic                     cap_ce
);

    logic                   ce_d;
    logic                   ce_rise;
    arcade_video_pkg::pix_t pix_q;
    logic                   hs_q;
    logic                   vs_q;
    logic                   hb_q;
    logic                   vb_q;

    assign ce_rise = ce_pix & ~ce_d;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ce_d   <= 1'b0;
            cap_ce <= 1'b0;
            hs_q   <= 1'b0;
            vs_q   <= 1'b0;
            hb_q   <= 1'b1;
            vb_q   <= 1'b1;
        end else begin
            ce_d   <= ce_pix;
            cap_ce <= ce_rise;
            if (ce_rise) begin
                hs_q <= hsync;
                // Vsync only changes at the start of an hsync pulse
                if (!hs_q && hsync) begin
                    vs_q <= vsync;
                end
                hb_q <= hblank;
                // Vblank only changes where a line's blanking ends
                if (hb_q && !hblank) begin
                    vb_q <= vblank;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ce_rise) begin
            pix_q <= pix_in;
        end
    end

    assign cap = '{pix: pix_q, hs: hs_q, vs: vs_q, hblank: hb_q, vblank: vb_q};

endmodule

// File: source/video_out_ctrl.sv
// Output control: picks the direct or rotated path once per frame
// Expands RGB332 to 24 bits and derives the scanline level from the effect setting

`timescale 1ns/1ps

module video_out_ctrl (
    input  logic                        clk,
    input  logic                        arst_n,
    input  arcade_video_pkg::mode_t     mode,
    input  arcade_video_pkg::video_t    cap,
    input  logic                        cap_ce,
    input  arcade_video_pkg::pix_t      rd_data,
    input  logic                        rd_tick,
    input  arcade_video_pkg::rd_phase_e phase,
    input  logic                        rot_hs,
    input  logic                        rot_vs,
    output logic                        ccw_active,
    output logic                        out_ce,
    output arcade_video_pkg::rgb_t      rgb,
    output logic                        hs,
    output logic                        vs,
    output logic                        de,
    output logic [1:0]                  scanline
);

    arcade_video_pkg::mode_t mode_q;
    arcade_video_pkg::pix_t  sel_pix;
    logic                    sel_ce;
    logic                    sel_hs;
    logic                    sel_vs;
    logic                    sel_de;
    logic                    vb_d;
    logic [2:0]              fx_m1;

    // Bit replication, so full scale maps to 8'hff
    function automatic arcade_video_pkg::rgb_t expand(input arcade_video_pkg::pix_t p);
        arcade_video_pkg::rgb_t c;
        c.r = {p.r, p.r, p.r[2:1]};
        c.g = {p.g, p.g, p.g[2:1]};
        c.b = {4{p.b}};
        return c;
    endfunction

    assign ccw_active = mode_q.ccw;
    assign fx_m1      = mode_q.fx - 3'd1;
    assign scanline   = (mode_q.fx != 3'd0) ? fx_m1[1:0] : 2'b00;

    always_comb begin
        if (mode_q.no_rotate) begin
            sel_ce  = cap_ce;
            sel_pix = cap.pix;
            sel_hs  = cap.hs;
            sel_vs  = cap.vs;
            sel_de  = ~(cap.hblank | cap.vblank);
        end else begin
            sel_ce  = rd_tick;
            sel_pix = rd_data;
            sel_hs  = rot_hs;
            sel_vs  = rot_vs;
            sel_de  = (phase == arcade_video_pkg::active);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode_q <= '0;
            vb_d   <= 1'b1;
            out_ce <= 1'b0;
            hs     <= 1'b0;
            vs     <= 1'b0;
            de     <= 1'b0;
        end else begin
            vb_d <= cap.vblank;
            // Mode only changes at the start of an input vblank
            if (cap.vblank && !vb_d) begin
                mode_q <= mode;
            end
            out_ce <= sel_ce;
            if (sel_ce) begin
                hs <= sel_hs;
                vs <= sel_vs;
                de <= sel_de;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sel_ce) begin
            rgb <= expand(sel_pix);
        end
    end

endmodule

// File: sources.f
common/arcade_video_pkg.sv
source/pixel_capture.sv
rotate/rotate_writer.sv
rotate/frame_buffer.sv
rotate/rotate_reader.sv
source/video_out_ctrl.sv
source/arcade_video_top.sv
verification/tb_clock.sv
verification/arcade_video_tb.sv

// File: verification/arcade_video_tb.sv
// Directed tests for the video output stage
// A repeating source frame is driven and output frames are checked against a model

`timescale 1ns/1ps

module arcade_video_tb;

    localparam int w            = arcade_video_pkg::src_width;
    localparam int h            = arcade_video_pkg::src_height;
    localparam int src_line_len = w + 8;
    localparam int src_vb_lines = 4;
    localparam int src_lines    = h + src_vb_lines;
    localparam int out_lines    = w + arcade_video_pkg::out_vblank_lines;
    localparam int change_line  = 8;
    localparam int path_direct  = 0;
    localparam int path_cw      = 1;
    localparam int path_ccw     = 2;
    localparam int num_tests    = 6;
    localparam int clk_ns       = 8;
    // Six output frames per test, two clocks per tick, 50 % margin
    localparam int timeout_ns   = num_tests * 6 * arcade_video_pkg::out_line_len * out_lines
                                  * 2 * clk_ns * 3 / 2;
    // Most de pixels the rotated path can emit during the active source lines
    localparam int max_rot_de   = ((h * src_line_len) / arcade_video_pkg::out_line_len + 1) * h;

    logic                    clk;
    logic                    arst_n;
    logic                    ce_pix;
    arcade_video_pkg::pix_t  pix_in;
    logic                    hsync;
    logic                    vsync;
    logic                    hblank;
    logic                    vblank;
    arcade_video_pkg::mode_t mode;
    logic                    out_ce;
    arcade_video_pkg::rgb_t  rgb;
    logic                    hs;
    logic                    vs;
    logic                    de;
    logic [1:0]              scanline;

    arcade_video_pkg::pix_t pat [h][w];
    arcade_video_pkg::rgb_t got [w * h];
    int                     px;
    int                     py;
    int                     cur_line;
    int                     frames_in;
    int unsigned            rng;
    int                     test_errors;
    int                     errors;
    int                     tests_failed;

    tb_clock clock0 (
        .clk    (clk),
        .arst_n (arst_n)
    );

    arcade_video_top dut0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .ce_pix   (ce_pix),
        .pix_in   (pix_in),
        .hsync    (hsync),
        .vsync    (vsync),
        .hblank   (hblank),
        .vblank   (vblank),
        .mode     (mode),
        .out_ce   (out_ce),
        .rgb      (rgb),
        .hs       (hs),
        .vs       (vs),
        .de       (de),
        .scanline (scanline)
    );

    // ============================================================
    // Reference model
    // ============================================================
    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // abc becomes abcabcab, ab becomes abababab
    function automatic arcade_video_pkg::rgb_t widen(input arcade_video_pkg::pix_t p);
        arcade_video_pkg::rgb_t c;
        c.r = {p.r, 5'b0} | {3'b0, p.r, 2'b0} | {6'b0, p.r[2:1]};
        c.g = {p.g, 5'b0} | {3'b0, p.g, 2'b0} | {6'b0, p.g[2:1]};
        c.b = p.b * 8'h55;
        return c;
    endfunction

    // Source pixel expected at an output row and column
    function automatic arcade_video_pkg::pix_t model_pix(input int path, input int row,
                                                         input int col);
        if (path == path_cw) begin
            return pat[h - 1 - col][row];
        end else if (path == path_ccw) begin
            return pat[col][w - 1 - row];
        end
        return pat[row][col];
    endfunction

    // ============================================================
    // Source frame driver, one pixel every two clocks
    // ============================================================
    always @(negedge clk) begin
        ce_pix <= ~ce_pix;
        if (!ce_pix) begin
            hblank   <= (px >= w);
            hsync    <= (px >= w + 2) && (px < w + 4);
            vblank   <= (py < src_vb_lines);
            vsync    <= (py >= 1) && (py < 3);
            pix_in   <= (py >= src_vb_lines && px < w) ? pat[py - src_vb_lines][px] : '0;
            cur_line <= py;
            if (px == 0 && py == 0) begin
                frames_in <= frames_in + 1;
            end
            if (px == src_line_len - 1) begin
                px <= 0;
                py <= (py == src_lines - 1) ? 0 : py + 1;
            end else begin
                px <= px + 1;
            end
        end
    end

    // ============================================================
    // Helpers
    // ============================================================
    task automatic flag_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, test_errors);
            tests_failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    task automatic set_mode(input int path, input logic [2:0] level);
        @(negedge clk);
        mode <= '{no_rotate: (path == path_direct), ccw: (path == path_ccw), fx: level};
    endtask

    task automatic wait_in_frames(input int n);
        int target;
        target = frames_in + n;
        wait (frames_in >= target);
    endtask

    // Returns on the output sample where a vs pulse ends
    task automatic wait_vs_end();
        do @(negedge clk); while (!(out_ce && vs));
        do @(negedge clk); while (!(out_ce && !vs));
    endtask

    // Lets both banks refill after a mode or pattern change
    task automatic settle();
        wait_in_frames(3);
        repeat (2) wait_vs_end();
    endtask

    task automatic fill_random();
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x++) begin
                rng = lcg_next(rng);
                pat[y][x] = rng[23:16];
            end
        end
    endtask

    // All ones, all zeros, alternating bits and per-channel extremes
    task automatic fill_extremes();
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x++) begin
                case ((x + 2 * y) % 6)
                    0:       pat[y][x] = 8'hff;
                    1:       pat[y][x] = 8'h00;
                    2:       pat[y][x] = 8'haa;
                    3:       pat[y][x] = 8'h55;
                    4:       pat[y][x] = 8'he3;
                    default: pat[y][x] = 8'h1c;
                endcase
            end
        end
    endtask

    // Gathers the de pixels of one output frame, row by row
    task automatic collect_frame(input int rows, input int cols);
        int   row;
        int   col;
        int   total;
        logic in_run;
        logic done;
        row    = 0;
        col    = 0;
        total  = 0;
        in_run = 1'b0;
        done   = 1'b0;
        wait_vs_end();
        while (!done) begin
            @(negedge clk);
            if (out_ce && vs) begin
                done = 1'b1;
            end else if (out_ce && de) begin
                if (row < rows && col < cols) begin
                    got[row * cols + col] = rgb;
                end
                col++;
                total++;
                in_run = 1'b1;
            end else if (out_ce && in_run) begin
                assert (col == cols) else
                    flag_error($sformatf("row %0d has %0d pixels, expected %0d", row, col, cols));
                row++;
                col    = 0;
                in_run = 1'b0;
            end
        end
        assert (row == rows && total == rows * cols) else
            flag_error($sformatf("frame has %0d rows and %0d pixels, expected %0d by %0d",
                                 row, total, rows, cols));
    endtask

    task automatic compare_frame(input int path, input int rows, input int cols);
        arcade_video_pkg::rgb_t want;
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < cols; c++) begin
                want = widen(model_pix(path, r, c));
                assert (got[r * cols + c] === want) else
                    flag_error($sformatf("path %0d row %0d col %0d: got %h, expected %h",
                                         path, r, c, got[r * cols + c], want));
            end
        end
    endtask

    task automatic frame_check(input int path);
        int rows;
        int cols;
        rows = (path == path_direct) ? h : w;
        cols = (path == path_direct) ? w : h;
        set_mode(path, 3'd0);
        settle();
        collect_frame(rows, cols);
        compare_frame(path, rows, cols);
    endtask

    // ============================================================
    // Tests
    // ============================================================
    task automatic test_timing();
        int   ticks;
        int   lines;
        int   de_lines;
        int   vs_ends;
        logic seg_de;
        logic seen_hs;
        logic hs_q;
        logic vs_q;
        logic done;
        wait_vs_end();
        do @(negedge clk); while (!(out_ce && vs));
        ticks    = 0;
        lines    = 0;
        de_lines = 0;
        vs_ends  = 0;
        seg_de   = 1'b0;
        seen_hs  = 1'b0;
        hs_q     = hs;
        vs_q     = 1'b1;
        done     = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (out_ce) begin
                if (vs && !vs_q) begin
                    done = 1'b1;
                end else begin
                    if (!vs && vs_q) begin
                        vs_ends++;
                    end
                    if (hs && !hs_q) begin
                        if (seen_hs) begin
                            assert (ticks == arcade_video_pkg::out_line_len) else
                                flag_error($sformatf("line has %0d ticks, expected %0d",
                                                     ticks, arcade_video_pkg::out_line_len));
                        end
                        seen_hs = 1'b1;
                        ticks   = 0;
                        lines++;
                        if (seg_de) begin
                            de_lines++;
                        end
                        seg_de = 1'b0;
                    end
                    ticks++;
                    if (de) begin
                        seg_de = 1'b1;
                    end
                end
                hs_q = hs;
                vs_q = vs;
            end
        end
        assert (lines == out_lines && de_lines == w && vs_ends == 1) else
            flag_error($sformatf("frame has %0d lines, %0d with de, %0d vs pulses",
                                 lines, de_lines, vs_ends));
    endtask

    task automatic test_scanline();
        int         count;
        logic [1:0] want;
        logic       done;
        for (int lvl = 0; lvl <= 4; lvl++) begin
            set_mode(path_direct, 3'(lvl));
            wait_in_frames(2);
            want = (lvl == 0) ? 2'd0 : 2'(lvl - 1);
            assert (scanline === want) else
                flag_error($sformatf("fx %0d: scanline %0d, expected %0d", lvl, scanline, want));
        end
        // Switch path and effect in the middle of the active lines
        do @(negedge clk); while (cur_line != change_line);
        mode  <= '{no_rotate: 1'b0, ccw: 1'b0, fx: 3'd2};
        count = 0;
        done  = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (cur_line == 0) begin
                done = 1'b1;
            end else begin
                if (out_ce && de) begin
                    count++;
                end
                assert (scanline === 2'd3) else
                    flag_error($sformatf("scanline changed to %0d within the frame", scanline));
            end
        end
        assert (count == (src_lines - change_line) * w) else
            flag_error($sformatf("%0d direct pixels after the switch, expected %0d",
                                 count, (src_lines - change_line) * w));
        do @(negedge clk); while (cur_line < src_vb_lines);
        assert (scanline === 2'd1) else
            flag_error($sformatf("scanline %0d after the frame boundary, expected 1", scanline));
        count = 0;
        done  = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (cur_line == 0) begin
                done = 1'b1;
            end else if (out_ce && de) begin
                count++;
            end
        end
        assert (count <= max_rot_de) else
            flag_error($sformatf("%0d de pixels in one source frame, rotated path not taken",
                                 count));
    endtask

    // ============================================================
    // Sequence and watchdog
    // ============================================================
    initial begin
        ce_pix       = 1'b0;
        pix_in       = '0;
        hsync        = 1'b0;
        vsync        = 1'b0;
        hblank       = 1'b1;
        vblank       = 1'b1;
        mode         = '{no_rotate: 1'b1, ccw: 1'b0, fx: 3'd0};
        px           = 0;
        py           = 0;
        cur_line     = 0;
        frames_in    = 0;
        rng          = 11;
        test_errors  = 0;
        errors       = 0;
        tests_failed = 0;
        fill_extremes();
        wait (arst_n);

        fill_random();
        frame_check(path_direct);
        finish_test("test 1 direct path");
        fill_random();
        frame_check(path_cw);
        finish_test("test 2 clockwise rotation");
        fill_random();
        frame_check(path_ccw);
        finish_test("test 3 counter-clockwise rotation");
        fill_extremes();
        frame_check(path_direct);
        frame_check(path_cw);
        finish_test("test 4 colour expansion");
        test_timing();
        finish_test("test 5 rotated timing");
        test_scanline();
        finish_test("test 6 scanline and mode switch");

        $display("Tests run: %0d, failed: %0d, errors: %0d", num_tests, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("Timeout: the tests did not complete within %0d ns", timeout_ns);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: verification/tb_clock.sv
// Testbench clock and reset source
// 8 ns clock, reset held low for the first four rising edges

`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule
